// File: verilog/opcode_tables.svh
// Opcode decode table

`ifndef OPCODE_TABLES_SVH
`define OPCODE_TABLES_SVH

// flag bytes in use
// 2a writes rX from rY and rZ
// 29 writes rX from rY and immediate Z
// 26 and 25 are the NEG forms with an immediate Y
// 50 reads rX and takes a relative target
// 1a and 19 are stores that read rX
// 20 is SET and 30 the wyde ops that also read rX
// 40 is JMP with its 24-bit offset
// trap rows carry no operands
localparam mmix_isa_pkg::op_entry_t e_trap = '{mmix_isa_pkg::iop_trap, 8'h00};
localparam mmix_isa_pkg::op_entry_t e_add_rr = '{mmix_isa_pkg::iop_add, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_add_ri = '{mmix_isa_pkg::iop_add, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_addu_rr = '{mmix_isa_pkg::iop_addu, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_addu_ri = '{mmix_isa_pkg::iop_addu, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_sub_rr = '{mmix_isa_pkg::iop_sub, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_sub_ri = '{mmix_isa_pkg::iop_sub, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_subu_rr = '{mmix_isa_pkg::iop_subu, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_subu_ri = '{mmix_isa_pkg::iop_subu, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_cmp_rr = '{mmix_isa_pkg::iop_cmp, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_cmp_ri = '{mmix_isa_pkg::iop_cmp, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_cmpu_rr = '{mmix_isa_pkg::iop_cmpu, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_cmpu_ri = '{mmix_isa_pkg::iop_cmpu, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_neg_r = '{mmix_isa_pkg::iop_sub, 8'h26};
localparam mmix_isa_pkg::op_entry_t e_neg_i = '{mmix_isa_pkg::iop_sub, 8'h25};
localparam mmix_isa_pkg::op_entry_t e_negu_r = '{mmix_isa_pkg::iop_subu, 8'h26};
localparam mmix_isa_pkg::op_entry_t e_negu_i = '{mmix_isa_pkg::iop_subu, 8'h25};
localparam mmix_isa_pkg::op_entry_t e_shl_rr = '{mmix_isa_pkg::iop_shl, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_shl_ri = '{mmix_isa_pkg::iop_shl, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_shr_rr = '{mmix_isa_pkg::iop_shr, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_shr_ri = '{mmix_isa_pkg::iop_shr, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_br = '{mmix_isa_pkg::iop_br, 8'h50};
localparam mmix_isa_pkg::op_entry_t e_pbr = '{mmix_isa_pkg::iop_pbr, 8'h50};
localparam mmix_isa_pkg::op_entry_t e_ld_rr = '{mmix_isa_pkg::iop_ld, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_ld_ri = '{mmix_isa_pkg::iop_ld, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_st_rr = '{mmix_isa_pkg::iop_st, 8'h1a};
localparam mmix_isa_pkg::op_entry_t e_st_ri = '{mmix_isa_pkg::iop_st, 8'h19};
localparam mmix_isa_pkg::op_entry_t e_logic_rr = '{mmix_isa_pkg::iop_logic, 8'h2a};
localparam mmix_isa_pkg::op_entry_t e_logic_ri = '{mmix_isa_pkg::iop_logic, 8'h29};
localparam mmix_isa_pkg::op_entry_t e_set = '{mmix_isa_pkg::iop_set, 8'h20};
localparam mmix_isa_pkg::op_entry_t e_wyde = '{mmix_isa_pkg::iop_wyde, 8'h30};
localparam mmix_isa_pkg::op_entry_t e_jmp = '{mmix_isa_pkg::iop_jmp, 8'h40};

// indexed by opcode, eight opcodes per row
localparam mmix_isa_pkg::op_entry_t op_table [256] = '{
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_add_rr, e_add_ri, e_addu_rr, e_addu_ri, e_sub_rr, e_sub_ri, e_subu_rr, e_subu_ri,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_cmp_rr, e_cmp_ri, e_cmpu_rr, e_cmpu_ri, e_neg_r, e_neg_i, e_negu_r, e_negu_i,
	e_shl_rr, e_shl_ri, e_shl_rr, e_shl_ri, e_shr_rr, e_shr_ri, e_shr_rr, e_shr_ri,
	e_br, e_br, e_br, e_br, e_br, e_br, e_br, e_br,
	e_br, e_br, e_br, e_br, e_br, e_br, e_br, e_br,
	e_pbr, e_pbr, e_pbr, e_pbr, e_pbr, e_pbr, e_pbr, e_pbr,
	e_pbr, e_pbr, e_pbr, e_pbr, e_pbr, e_pbr, e_pbr, e_pbr,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_ld_rr, e_ld_ri, e_ld_rr, e_ld_ri, e_ld_rr, e_ld_ri, e_ld_rr, e_ld_ri,
	e_ld_rr, e_ld_ri, e_ld_rr, e_ld_ri, e_ld_rr, e_ld_ri, e_ld_rr, e_ld_ri,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_st_rr, e_st_ri, e_st_rr, e_st_ri, e_st_rr, e_st_ri, e_st_rr, e_st_ri,
	e_st_rr, e_st_ri, e_st_rr, e_st_ri, e_st_rr, e_st_ri, e_st_rr, e_st_ri,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_logic_rr, e_logic_ri, e_logic_rr, e_logic_ri, e_logic_rr, e_logic_ri, e_logic_rr, e_logic_ri,
	e_logic_rr, e_logic_ri, e_logic_rr, e_logic_ri, e_logic_rr, e_logic_ri, e_logic_rr, e_logic_ri,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_set, e_set, e_set, e_set, e_wyde, e_wyde, e_wyde, e_wyde,
	e_wyde, e_wyde, e_wyde, e_wyde, e_wyde, e_wyde, e_wyde, e_wyde,
	e_jmp, e_jmp, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap,
	e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap, e_trap
};

`endif

// File: verilog/mmix_isa_pkg.sv
// MMIX instruction set definitions
`default_nettype none

package mmix_isa_pkg;

	// internal operations handed to the execution units
	// every unsupported opcode collapses onto iop_trap
	typedef enum logic [4:0] {
		iop_trap,
		iop_add,
		iop_addu,
		iop_sub,
		iop_subu,
		iop_cmp,
		iop_cmpu,
		iop_shl,
		iop_shr,
		iop_logic,
		iop_br,
		iop_pbr,
		iop_ld,
		iop_st,
		iop_set,
		iop_wyde,
		iop_jmp,
		// TRIP seen in privileged space
		iop_noop
	} iop_t;

	// bit positions in the 8-bit operand flags

	// Z field is an immediate
	localparam logic [2:0] Z_IMM_BIT = 3'd0;
	// rZ is a source register
	localparam logic [2:0] Z_REG_BIT = 3'd1;
	// Y field is an immediate
	localparam logic [2:0] Y_IMM_BIT = 3'd2;
	// rY is a source register
	localparam logic [2:0] Y_REG_BIT = 3'd3;
	// rX is read as a source
	localparam logic [2:0] X_SRC_BIT = 3'd4;
	// rX is written
	localparam logic [2:0] X_DEST_BIT = 3'd5;
	// YZ or XYZ form a relative address
	localparam logic [2:0] REL_ADDR_BIT = 3'd6;

	// opcodes the decoder looks at directly
	localparam logic [7:0] JMP = 8'hf0;
	localparam logic [7:0] TRIP = 8'hff;
	// first of the sixteen wyde opcodes
	localparam logic [7:0] SETH = 8'he0;

	// one row of the opcode table
	typedef struct packed {
		iop_t iop;
		logic [7:0] flags;
	} op_entry_t;

endpackage

`default_nettype wire

// File: verilog/decode_pkg.sv
// Decoded operand types
`default_nettype none

package decode_pkg;

	// what an operand spec refers to
	typedef enum logic [1:0] {
		spec_none,
		spec_imm,
		spec_global,
		spec_local
	} spec_kind_t;

	// register view of the payload
	// upper bits stay zero
	typedef struct packed {
		logic [55:0] zero;
		logic [7:0] addr;
	} reg_view_t;

	// one payload word read either as an immediate or as a register address
	typedef union packed {
		logic [63:0] imm;
		reg_view_t rv;
	} spec_payload_t;

	// kind selects which payload view is meaningful
	typedef struct packed {
		spec_kind_t kind;
		spec_payload_t val;
	} spec_t;

endpackage

`default_nettype wire

// File: verilog/opcode_classify.sv
// Opcode classify stage
`timescale 1ns/1ns
`default_nettype none

module opcode_classify (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic [31:0] inst,
	input logic [63:0] loc,
	input logic [7:0] g,
	input logic [7:0] l,
	input logic [60:0] o,
	output logic s1_valid,
	output mmix_isa_pkg::iop_t s1_iop,
	output logic [7:0] s1_flags,
	output logic [7:0] s1_op,
	output logic [7:0] s1_xx,
	output logic [7:0] s1_yy,
	output logic [7:0] s1_zz,
	output logic [63:0] s1_loc,
	output logic [7:0] s1_g,
	output logic [7:0] s1_l,
	output logic [60:0] s1_o
);

	`include "opcode_tables.svh"

	logic [7:0] op;
	mmix_isa_pkg::op_entry_t entry;

	// opcode sits in the top byte
	assign op = inst[31:24];

	always_comb begin
		entry = op_table[op];
		// TRIP from privileged space is ignored
		if (op == mmix_isa_pkg::TRIP && loc[63])
			entry = '{mmix_isa_pkg::iop_noop, 8'h00};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	// stack state rides along with its own instruction
	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_iop <= entry.iop;
			s1_flags <= entry.flags;
			s1_op <= op;
			s1_xx <= inst[23:16];
			s1_yy <= inst[15:8];
			s1_zz <= inst[7:0];
			s1_loc <= loc;
			s1_g <= g;
			s1_l <= l;
			s1_o <= o;
		end
	end

endmodule

`default_nettype wire

// File: verilog/operand_resolve.sv
// Operand resolve stage
`timescale 1ns/1ns
`default_nettype none

module operand_resolve #(
	parameter int LRING_BITS = 8
) (
	input logic clk,
	input logic arst_n,
	input logic s1_valid,
	input mmix_isa_pkg::iop_t s1_iop,
	input logic [7:0] s1_flags,
	input logic [7:0] s1_op,
	input logic [7:0] s1_xx,
	input logic [7:0] s1_yy,
	input logic [7:0] s1_zz,
	input logic [63:0] s1_loc,
	input logic [7:0] s1_g,
	input logic [7:0] s1_l,
	input logic [60:0] s1_o,
	output logic out_valid,
	output logic [63:0] out_loc,
	output mmix_isa_pkg::iop_t out_iop,
	output decode_pkg::spec_t out_y,
	output decode_pkg::spec_t out_z,
	output decode_pkg::spec_t out_b,
	output decode_pkg::spec_t out_x,
	output logic out_ren_x,
	output logic out_marginal
);

	// keeps local addresses inside the register ring
	localparam logic [7:0] RING_MASK = 8'((1 << LRING_BITS) - 1);

	// global at or above g, otherwise a slot in the ring past o
	function automatic decode_pkg::spec_t reg_spec(input logic [7:0] r, input logic [7:0] gg,
			input logic [60:0] oo);
		decode_pkg::spec_t s;
		s.val.imm = 64'd0;
		if (r >= gg) begin
			s.kind = decode_pkg::spec_global;
			s.val.rv.addr = r;
		end else begin
			s.kind = decode_pkg::spec_local;
			s.val.rv.addr = (oo[7:0] + r) & RING_MASK;
		end
		return s;
	endfunction

	function automatic decode_pkg::spec_t imm_spec(input logic [63:0] v);
		decode_pkg::spec_t s;
		s.kind = decode_pkg::spec_imm;
		s.val.imm = v;
		return s;
	endfunction

	logic [63:0] rel_off;
	logic [63:0] wyde_imm;
	decode_pkg::spec_t x_reg;
	decode_pkg::spec_t y_c;
	decode_pkg::spec_t z_c;
	decode_pkg::spec_t b_c;
	decode_pkg::spec_t x_c;
	logic ren_c;
	logic marg_c;

	// rX resolved once and shared by wyde Y, B and destination
	assign x_reg = reg_spec(s1_xx, s1_g, s1_o);

	// Y and Z operands
	always_comb begin
		rel_off = 64'd0;
		wyde_imm = 64'd0;
		y_c = '0;
		z_c = '0;
		if (s1_flags[mmix_isa_pkg::REL_ADDR_BIT]) begin
			// odd opcodes are the backward forms
			if ((s1_op & 8'hfe) == mmix_isa_pkg::JMP)
				rel_off = {{38{s1_op[0]}}, s1_xx, s1_yy, s1_zz, 2'b00};
			else
				rel_off = {{46{s1_op[0]}}, s1_yy, s1_zz, 2'b00};
			y_c = imm_spec(s1_loc + 64'd4);
			z_c = imm_spec(s1_loc + rel_off);
		end else if (s1_op[7:4] == mmix_isa_pkg::SETH[7:4]) begin
			// low two opcode bits pick the wyde position
			case (s1_op[1:0])
				2'd0: wyde_imm = {s1_yy, s1_zz, 48'd0};
				2'd1: wyde_imm = {16'd0, s1_yy, s1_zz, 32'd0};
				2'd2: wyde_imm = {32'd0, s1_yy, s1_zz, 16'd0};
				default: wyde_imm = {48'd0, s1_yy, s1_zz};
			endcase
			z_c = imm_spec(wyde_imm);
			// INC, OR and ANDN combine with the old rX
			if (s1_iop != mmix_isa_pkg::iop_set)
				y_c = x_reg;
		end else begin
			if (s1_flags[mmix_isa_pkg::Z_IMM_BIT])
				z_c = imm_spec({56'd0, s1_zz});
			else if (s1_flags[mmix_isa_pkg::Z_REG_BIT])
				z_c = reg_spec(s1_zz, s1_g, s1_o);
			if (s1_flags[mmix_isa_pkg::Y_IMM_BIT])
				y_c = imm_spec({56'd0, s1_yy});
			else if (s1_flags[mmix_isa_pkg::Y_REG_BIT])
				y_c = reg_spec(s1_yy, s1_g, s1_o);
		end
	end

	// B source and X destination
	always_comb begin
		b_c = '0;
		x_c = '0;
		ren_c = 1'b0;
		marg_c = 1'b0;
		if (s1_flags[mmix_isa_pkg::X_SRC_BIT])
			b_c = x_reg;
		if (s1_flags[mmix_isa_pkg::X_DEST_BIT]) begin
			if (s1_xx >= s1_g || s1_xx < s1_l) begin
				ren_c = 1'b1;
				x_c = x_reg;
			end else begin
				// between L and G so the register is not yet allocated
				marg_c = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_ren_x <= 1'b0;
			out_marginal <= 1'b0;
		end else begin
			out_valid <= s1_valid;
			if (s1_valid) begin
				out_ren_x <= ren_c;
				out_marginal <= marg_c;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			out_loc <= s1_loc;
			out_iop <= s1_iop;
			out_y <= y_c;
			out_z <= z_c;
			out_b <= b_c;
			out_x <= x_c;
		end
	end

endmodule

`default_nettype wire

// File: verilog/inst_decoder_top.sv
// Two-stage instruction decoder
`timescale 1ns/1ns
`default_nettype none

module inst_decoder_top #(
	parameter int LRING_BITS = 8
) (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic [31:0] inst,
	input logic [63:0] loc,
	input logic [7:0] g,
	input logic [7:0] l,
	input logic [60:0] o,
	output logic out_valid,
	output logic [63:0] out_loc,
	output mmix_isa_pkg::iop_t out_iop,
	output decode_pkg::spec_t out_y,
	output decode_pkg::spec_t out_z,
	output decode_pkg::spec_t out_b,
	output decode_pkg::spec_t out_x,
	output logic out_ren_x,
	output logic out_marginal
);

	// stage 1 to stage 2 bundle
	logic s1_valid;
	mmix_isa_pkg::iop_t s1_iop;
	logic [7:0] s1_flags;
	logic [7:0] s1_op;
	logic [7:0] s1_xx;
	logic [7:0] s1_yy;
	logic [7:0] s1_zz;
	logic [63:0] s1_loc;
	logic [7:0] s1_g;
	logic [7:0] s1_l;
	logic [60:0] s1_o;

	// field split and table lookup
	opcode_classify i_opcode_classify (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.inst(inst),
		.loc(loc),
		.g(g),
		.l(l),
		.o(o),
		.s1_valid(s1_valid),
		.s1_iop(s1_iop),
		.s1_flags(s1_flags),
		.s1_op(s1_op),
		.s1_xx(s1_xx),
		.s1_yy(s1_yy),
		.s1_zz(s1_zz),
		.s1_loc(s1_loc),
		.s1_g(s1_g),
		.s1_l(s1_l),
		.s1_o(s1_o)
	);

	// operand and destination resolution
	operand_resolve #(
		.LRING_BITS(LRING_BITS)
	) i_operand_resolve (
		.clk(clk),
		.arst_n(arst_n),
		.s1_valid(s1_valid),
		.s1_iop(s1_iop),
		.s1_flags(s1_flags),
		.s1_op(s1_op),
		.s1_xx(s1_xx),
		.s1_yy(s1_yy),
		.s1_zz(s1_zz),
		.s1_loc(s1_loc),
		.s1_g(s1_g),
		.s1_l(s1_l),
		.s1_o(s1_o),
		.out_valid(out_valid),
		.out_loc(out_loc),
		.out_iop(out_iop),
		.out_y(out_y),
		.out_z(out_z),
		.out_b(out_b),
		.out_x(out_x),
		.out_ren_x(out_ren_x),
		.out_marginal(out_marginal)
	);

endmodule

`default_nettype wire

// File: tests/inst_decoder_asserts.sv
// Decoder port assertions
`timescale 1ns/1ns
`default_nettype none

module inst_decoder_asserts (
	input logic clk,
	input logic arst_n,
	input logic in_valid,
	input logic out_valid,
	input logic out_ren_x,
	input logic out_marginal
);

	// fixed two-stage latency, no stalls
	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid == $past(in_valid, 2))
		else $error("out_valid does not follow in_valid by two cycles");

	// a destination is either renamed or marginal
	assert property (@(posedge clk) disable iff (!arst_n)
		!(out_ren_x && out_marginal))
		else $error("out_ren_x and out_marginal are high together");

	assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(out_valid))
		else $error("out_valid is unknown");

endmodule

`default_nettype wire

// File: tests/inst_decoder_tb.sv
// Instruction decoder testbench
`timescale 1ns/1ns
`default_nettype none

module inst_decoder_tb;

	localparam int RING_BITS = 8;
	localparam int NUM_INST = 400;
	localparam int DRAIN_CYCLES = 20;

	// one expected decode result
	typedef struct packed {
		logic [63:0] loc;
		mmix_isa_pkg::iop_t iop;
		decode_pkg::spec_t y;
		decode_pkg::spec_t z;
		decode_pkg::spec_t b;
		decode_pkg::spec_t x;
		logic ren_x;
		logic marginal;
	} expect_t;

	logic clk = 1'b0;
	logic arst_n;
	logic in_valid;
	logic [31:0] inst;
	logic [63:0] loc;
	logic [7:0] g;
	logic [7:0] l;
	logic [60:0] o;
	logic out_valid;
	logic [63:0] out_loc;
	mmix_isa_pkg::iop_t out_iop;
	decode_pkg::spec_t out_y;
	decode_pkg::spec_t out_z;
	decode_pkg::spec_t out_b;
	decode_pkg::spec_t out_x;
	logic out_ren_x;
	logic out_marginal;

	// expected results and the cycle each one went in
	expect_t exp_q[$];
	int cyc_q[$];
	int cycle = 0;

	inst_decoder_top #(
		.LRING_BITS(RING_BITS)
	) i_inst_decoder_top (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.inst(inst),
		.loc(loc),
		.g(g),
		.l(l),
		.o(o),
		.out_valid(out_valid),
		.out_loc(out_loc),
		.out_iop(out_iop),
		.out_y(out_y),
		.out_z(out_z),
		.out_b(out_b),
		.out_x(out_x),
		.out_ren_x(out_ren_x),
		.out_marginal(out_marginal)
	);

	bind inst_decoder_top inst_decoder_asserts i_inst_decoder_asserts (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.out_valid(out_valid),
		.out_ren_x(out_ren_x),
		.out_marginal(out_marginal)
	);

	// 100 ns period
	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [65:0] got,
			input logic [65:0] exp);
		assert (got === exp)
		else stop_with_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
			$time, name, got, exp));
	endtask

	// opcode table written out by class
	function automatic mmix_isa_pkg::op_entry_t table_ref(input logic [7:0] op);
		mmix_isa_pkg::op_entry_t ent;
		ent.iop = mmix_isa_pkg::iop_trap;
		ent.flags = 8'h00;
		// even opcodes take rZ, odd ones an immediate Z
		case (op[7:4])
			4'h2: if (!op[3]) begin
				ent.flags = op[0] ? 8'h29 : 8'h2a;
				case (op[2:1])
					2'd0: ent.iop = mmix_isa_pkg::iop_add;
					2'd1: ent.iop = mmix_isa_pkg::iop_addu;
					2'd2: ent.iop = mmix_isa_pkg::iop_sub;
					default: ent.iop = mmix_isa_pkg::iop_subu;
				endcase
			end
			4'h3: if (op[3]) begin
				ent.flags = op[0] ? 8'h29 : 8'h2a;
				ent.iop = op[2] ? mmix_isa_pkg::iop_shr : mmix_isa_pkg::iop_shl;
			end else if (op[2]) begin
				// NEG forms with an immediate Y
				ent.flags = op[0] ? 8'h25 : 8'h26;
				ent.iop = op[1] ? mmix_isa_pkg::iop_subu : mmix_isa_pkg::iop_sub;
			end else begin
				ent.flags = op[0] ? 8'h29 : 8'h2a;
				ent.iop = op[1] ? mmix_isa_pkg::iop_cmpu : mmix_isa_pkg::iop_cmp;
			end
			4'h4: ent = '{mmix_isa_pkg::iop_br, 8'h50};
			4'h5: ent = '{mmix_isa_pkg::iop_pbr, 8'h50};
			4'h8: ent = '{mmix_isa_pkg::iop_ld, op[0] ? 8'h29 : 8'h2a};
			4'ha: ent = '{mmix_isa_pkg::iop_st, op[0] ? 8'h19 : 8'h1a};
			4'hc: ent = '{mmix_isa_pkg::iop_logic, op[0] ? 8'h29 : 8'h2a};
			4'he: if (op[3:2] == 2'd0)
				ent = '{mmix_isa_pkg::iop_set, 8'h20};
			else
				ent = '{mmix_isa_pkg::iop_wyde, 8'h30};
			4'hf: if (op[3:1] == 3'd0)
				ent = '{mmix_isa_pkg::iop_jmp, 8'h40};
			default: ent.iop = mmix_isa_pkg::iop_trap;
		endcase
		return ent;
	endfunction

	function automatic decode_pkg::spec_t imm_ref(input logic [63:0] v);
		decode_pkg::spec_t s;
		s.kind = decode_pkg::spec_imm;
		s.val.imm = v;
		return s;
	endfunction

	// register numbers below g live in the ring after o
	function automatic decode_pkg::spec_t reg_ref(input logic [7:0] r, input logic [7:0] gg,
			input logic [60:0] oo);
		decode_pkg::spec_t s;
		s.kind = (r >= gg) ? decode_pkg::spec_global : decode_pkg::spec_local;
		if (r >= gg)
			s.val.imm = 64'(r);
		else
			s.val.imm = (64'(oo) + 64'(r)) & ((64'd1 << RING_BITS) - 64'd1);
		return s;
	endfunction

	function automatic expect_t decode_ref(input logic [31:0] word, input logic [63:0] pc,
			input logic [7:0] gg, input logic [7:0] ll, input logic [60:0] oo);
		expect_t e;
		mmix_isa_pkg::op_entry_t ent;
		decode_pkg::spec_t xr;
		logic [7:0] op;
		logic [7:0] xx;
		logic [7:0] yy;
		logic [7:0] zz;
		logic [63:0] off;
		op = word[31:24];
		xx = word[23:16];
		yy = word[15:8];
		zz = word[7:0];
		e = '0;
		e.loc = pc;
		ent = table_ref(op);
		if (op == mmix_isa_pkg::TRIP && pc[63])
			ent = '{mmix_isa_pkg::iop_noop, 8'h00};
		e.iop = ent.iop;
		xr = reg_ref(xx, gg, oo);
		if (ent.flags[mmix_isa_pkg::REL_ADDR_BIT]) begin
			// word offset, backward when the opcode is odd
			if (op[7:1] == mmix_isa_pkg::JMP[7:1])
				off = 64'({xx, yy, zz}) - (op[0] ? 64'h100_0000 : 64'd0);
			else
				off = 64'({yy, zz}) - (op[0] ? 64'h1_0000 : 64'd0);
			e.y = imm_ref(pc + 64'd4);
			e.z = imm_ref(pc + (off << 2));
		end else if (op[7:4] == mmix_isa_pkg::SETH[7:4]) begin
			e.z = imm_ref(64'({yy, zz}) << (48 - 16 * int'(op[1:0])));
			if (op[3:2] != 2'd0)
				e.y = xr;
		end else begin
			if (ent.flags[mmix_isa_pkg::Z_IMM_BIT])
				e.z = imm_ref(64'(zz));
			else if (ent.flags[mmix_isa_pkg::Z_REG_BIT])
				e.z = reg_ref(zz, gg, oo);
			if (ent.flags[mmix_isa_pkg::Y_IMM_BIT])
				e.y = imm_ref(64'(yy));
			else if (ent.flags[mmix_isa_pkg::Y_REG_BIT])
				e.y = reg_ref(yy, gg, oo);
		end
		if (ent.flags[mmix_isa_pkg::X_SRC_BIT])
			e.b = xr;
		if (ent.flags[mmix_isa_pkg::X_DEST_BIT]) begin
			// between l and g the destination is marginal
			if (xx >= gg || xx < ll) begin
				e.ren_x = 1'b1;
				e.x = xr;
			end else begin
				e.marginal = 1'b1;
			end
		end
		return e;
	endfunction

	// weighted toward the supported classes
	function automatic logic [7:0] pick_opcode();
		int unsigned c;
		c = $urandom % 10;
		case (c)
			0, 1: return 8'h20 + 8'($urandom % 32);
			2: return 8'h80 + 8'($urandom % 16);
			3: return 8'ha0 + 8'($urandom % 16);
			4: return 8'hc0 + 8'($urandom % 16);
			5: return 8'h40 + 8'($urandom % 32);
			6: return 8'hf0 + 8'($urandom % 2);
			7: return 8'he0 + 8'($urandom % 16);
			8: return mmix_isa_pkg::TRIP;
			// floating point, multiply and divide
			default: return 8'($urandom % 32);
		endcase
	endfunction

	// register numbers near the l and g boundaries
	function automatic logic [7:0] pick_reg(input logic [7:0] gg, input logic [7:0] ll);
		int unsigned c;
		c = $urandom % 5;
		case (c)
			0: return ll - 8'd1;
			1: return ll;
			2: return gg - 8'd1;
			3: return gg;
			default: return 8'($urandom);
		endcase
	endfunction

	task automatic drive_one();
		logic [7:0] op;
		logic [7:0] gg;
		logic [7:0] ll;
		gg = 8'(32 + $urandom % 224);
		ll = 8'($urandom % (int'(gg) + 1));
		op = pick_opcode();
		inst = {op, pick_reg(gg, ll), pick_reg(gg, ll), pick_reg(gg, ll)};
		loc = {$urandom, $urandom};
		g = gg;
		l = ll;
		o = 61'({$urandom, $urandom});
		in_valid = 1'b1;
		exp_q.push_back(decode_ref(inst, loc, g, l, o));
		cyc_q.push_back(cycle);
	endtask

	// outputs are registered, so mid-cycle values are settled
	always @(negedge clk) begin : compare
		expect_t e;
		int issued;
		if (!arst_n) begin
			assert (!out_valid && !out_ren_x && !out_marginal)
			else stop_with_failure("outputs were active during reset");
		end else if (out_valid) begin
			assert (exp_q.size() > 0)
			else stop_with_failure("out_valid came with no instruction pending");
			e = exp_q.pop_front();
			issued = cyc_q.pop_front();
			check_value("out_valid latency", 66'(cycle - issued), 66'd2);
			check_value("out_loc", 66'(out_loc), 66'(e.loc));
			check_value("out_iop", 66'(out_iop), 66'(e.iop));
			check_value("out_y", out_y, e.y);
			check_value("out_z", out_z, e.z);
			check_value("out_b", out_b, e.b);
			check_value("out_x", out_x, e.x);
			check_value("out_ren_x", 66'(out_ren_x), 66'(e.ren_x));
			check_value("out_marginal", 66'(out_marginal), 66'(e.marginal));
		end else if (cyc_q.size() > 0) begin
			assert (cycle - cyc_q[0] < 2)
			else stop_with_failure("out_valid did not come two cycles after in_valid");
		end
	end

	initial begin
		int n;
		void'($urandom(28));
		arst_n = 1'b0;
		in_valid = 1'b0;
		inst = 32'd0;
		loc = 64'd0;
		g = 8'd32;
		l = 8'd0;
		o = 61'd0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		assert (!out_valid && !out_ren_x && !out_marginal)
		else stop_with_failure("outputs were active right after reset");
		for (n = 0; n < NUM_INST; n++) begin
			@(negedge clk);
			// idle slots between runs of back-to-back instructions
			if ($urandom % 4 == 0)
				in_valid = 1'b0;
			else
				drive_one();
		end
		@(negedge clk);
		in_valid = 1'b0;
		for (n = 0; n < DRAIN_CYCLES && exp_q.size() != 0; n++)
			@(negedge clk);
		if (exp_q.size() != 0) begin
			stop_with_failure("out_valid never came for the last instructions");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/mmix_isa_pkg.sv
verilog/decode_pkg.sv
verilog/opcode_classify.sv
verilog/operand_resolve.sv
verilog/inst_decoder_top.sv
tests/inst_decoder_asserts.sv
tests/inst_decoder_tb.sv

// File: run.sh
#!/bin/sh
# build the decoder testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module inst_decoder_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vinst_decoder_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0
